// ==== design/isaPkg.sv ====
package isaPkg;

    localparam int WordW = 16;
    localparam int NumRegs = 4;
    localparam int RegW = $clog2(NumRegs);

    typedef enum logic [3:0] {
        OpBne   = 4'd0,
        OpBeq   = 4'd1,
        OpAdi   = 4'd4,
        OpLhi   = 4'd6,
        OpLwd   = 4'd7,
        OpSwd   = 4'd8,
        OpJmp   = 4'd9,
        OpRtype = 4'd15
    } opcodeE;

    typedef enum logic [5:0] {
        FnAdd = 6'd0,
        FnSub = 6'd1,
        FnAnd = 6'd2,
        FnOrr = 6'd3,
        FnWwd = 6'd28,
        FnHlt = 6'd29
    } funcE;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluPassA,
        AluLhi
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  memToReg;
        logic  memRead;
        logic  memWrite;
        logic  isBranch;
        logic  branchOnEqual;
        logic  aluSrcImm;
        aluOpE aluOp;
        logic  isWwd;
        logic  isHalt;
        logic  isJump;
        logic  usesRs;
        logic  usesRt;
    } ctrlT;

endpackage

// ==== design/pipePkg.sv ====
package pipePkg;

    // Operand source picked for execute
    typedef enum logic [1:0] {
        FwdNone,
        FwdMem,
        FwdWb
    } fwdSelE;

    typedef struct packed {
        logic [isaPkg::WordW-1:0] pcPlus1;
        logic [isaPkg::WordW-1:0] instr;
        logic                     valid;
    } ifIdT;

    typedef struct packed {
        isaPkg::ctrlT             ctrl;
        logic [isaPkg::WordW-1:0] pcPlus1;
        logic [isaPkg::WordW-1:0] readA;
        logic [isaPkg::WordW-1:0] readB;
        logic [isaPkg::RegW-1:0]  rs;
        logic [isaPkg::RegW-1:0]  rt;
        logic [isaPkg::RegW-1:0]  dest;
        logic [isaPkg::WordW-1:0] imm;
        logic                     valid;
    } idExT;

    typedef struct packed {
        isaPkg::ctrlT             ctrl;
        logic [isaPkg::WordW-1:0] aluResult;
        logic [isaPkg::WordW-1:0] storeData;
        logic [isaPkg::RegW-1:0]  dest;
        logic                     valid;
    } exMemT;

    typedef struct packed {
        isaPkg::ctrlT             ctrl;
        logic [isaPkg::WordW-1:0] aluResult;
        logic [isaPkg::WordW-1:0] loadData;
        logic [isaPkg::RegW-1:0]  dest;
        logic                     valid;
    } memWbT;

endpackage

// ==== design/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit (
    input  logic [isaPkg::WordW-1:0] instr,
    input  logic                     valid,
    output isaPkg::ctrlT             ctrl
);
    import isaPkg::*;

    always_comb begin
        ctrl = '0;
        if (valid) begin
            case (opcodeE'(instr[15:12]))
                OpRtype: begin
                    case (funcE'(instr[5:0]))
                        FnAdd, FnSub, FnAnd, FnOrr: begin
                            ctrl.regWrite = 1'b1;
                            ctrl.usesRs = 1'b1;
                            ctrl.usesRt = 1'b1;
                            case (funcE'(instr[5:0]))
                                FnSub: ctrl.aluOp = AluSub;
                                FnAnd: ctrl.aluOp = AluAnd;
                                FnOrr: ctrl.aluOp = AluOr;
                                default: ctrl.aluOp = AluAdd;
                            endcase
                        end
                        FnWwd: begin
                            ctrl.isWwd = 1'b1;
                            ctrl.aluOp = AluPassA;
                            ctrl.usesRs = 1'b1;
                        end
                        FnHlt: ctrl.isHalt = 1'b1;
                        default: ctrl = '0;
                    endcase
                end
                OpAdi: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.usesRs = 1'b1;
                end
                OpLhi: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp = AluLhi;
                end
                OpLwd: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.usesRs = 1'b1;
                end
                OpSwd: begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.usesRs = 1'b1;
                    ctrl.usesRt = 1'b1;
                end
                OpBne, OpBeq: begin
                    ctrl.isBranch = 1'b1;
                    ctrl.branchOnEqual = (opcodeE'(instr[15:12]) == OpBeq);
                    ctrl.aluOp = AluSub;
                    ctrl.usesRs = 1'b1;
                    ctrl.usesRt = 1'b1;
                end
                OpJmp: ctrl.isJump = 1'b1;
                default: ctrl = '0;
            endcase
        end
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ns

module regFile (
    input  logic                     Clk,
    input  logic                     rst,
    input  logic [isaPkg::RegW-1:0]  readAddrA,
    input  logic [isaPkg::RegW-1:0]  readAddrB,
    input  logic [isaPkg::RegW-1:0]  writeAddr,
    input  logic [isaPkg::WordW-1:0] writeData,
    input  logic                     writeEnable,
    output logic [isaPkg::WordW-1:0] readDataA,
    output logic [isaPkg::WordW-1:0] readDataB
);
    import isaPkg::*;

    logic [WordW-1:0] regs [NumRegs];

    always_ff @(posedge Clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Write-through so decode reads the value retiring this cycle
    assign readDataA = (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  logic [isaPkg::WordW-1:0] operandA,
    input  logic [isaPkg::WordW-1:0] operandB,
    input  logic [isaPkg::WordW-1:0] imm,
    input  isaPkg::aluOpE            aluOp,
    output logic [isaPkg::WordW-1:0] result,
    output logic                     zero
);
    import isaPkg::*;

    localparam int HalfW = WordW / 2;

    always_comb begin
        case (aluOp)
            AluAdd: result = operandA + operandB;
            AluSub: result = operandA - operandB;
            AluAnd: result = operandA & operandB;
            AluOr: result = operandA | operandB;
            AluPassA: result = operandA;
            // Low byte of the immediate moves to the high byte
            AluLhi: result = {imm[HalfW-1:0], {HalfW{1'b0}}};
            default: result = '0;
        endcase
    end

    // Branch compare uses the subtract result
    assign zero = (result == '0);

endmodule

// ==== design/hazardUnit.sv ====
`timescale 1ns/1ns

module hazardUnit (
    input  logic                    [isaPkg::RegW-1:0] idRs,
    input  logic                    [isaPkg::RegW-1:0] idRt,
    input  logic                    [isaPkg::RegW-1:0] exRs,
    input  logic                    [isaPkg::RegW-1:0] exRt,
    input  logic                    idUsesRs,
    input  logic                    idUsesRt,
    input  logic                    exUsesRs,
    input  logic                    exUsesRt,
    input  logic                    exIsLoad,
    input  logic [isaPkg::RegW-1:0] exDest,
    input  logic [isaPkg::RegW-1:0] memDest,
    input  logic [isaPkg::RegW-1:0] wbDest,
    input  logic                    memRegWrite,
    input  logic                    wbRegWrite,
    output pipePkg::fwdSelE         fwdA,
    output pipePkg::fwdSelE         fwdB,
    output logic                    stall
);
    import isaPkg::*;
    import pipePkg::*;

    // Youngest writer wins, so memory is checked before write-back
    function automatic fwdSelE pickSource(input logic uses, input logic [RegW-1:0] src);
        if (uses && memRegWrite && memDest == src) begin
            return FwdMem;
        end else if (uses && wbRegWrite && wbDest == src) begin
            return FwdWb;
        end
        return FwdNone;
    endfunction

    assign fwdA = pickSource(exUsesRs, exRs);
    assign fwdB = pickSource(exUsesRt, exRt);

    // Load data only exists after memory, one bubble covers the gap
    assign stall = exIsLoad && ((idUsesRs && idRs == exDest) || (idUsesRt && idRt == exDest));

endmodule

// ==== design/datapath.sv ====
`timescale 1ns/1ns

module datapath (
    input  logic                     Clk,
    input  logic                     rst,
    output logic [isaPkg::WordW-1:0] idInstr,
    output logic                     idValid,
    input  isaPkg::ctrlT             idCtrl,
    output logic [isaPkg::WordW-1:0] instAddr,
    output logic                     instRead,
    input  logic [isaPkg::WordW-1:0] instData,
    output logic [isaPkg::WordW-1:0] dataAddr,
    output logic                     dataRead,
    output logic                     dataWrite,
    output logic [isaPkg::WordW-1:0] dataWriteValue,
    input  logic [isaPkg::WordW-1:0] dataReadValue,
    output logic [isaPkg::WordW-1:0] outputPort,
    output logic                     outputValid,
    output logic [isaPkg::WordW-1:0] numInst,
    output logic                     halted
);
    import isaPkg::*;
    import pipePkg::*;

    logic [WordW-1:0] pc;
    logic [WordW-1:0] pcPlus1;
    logic [WordW-1:0] nextPc;
    ifIdT ifId;
    idExT idEx;
    exMemT exMem;
    memWbT memWb;

    logic [RegW-1:0] idDest;
    logic [WordW-1:0] idReadA;
    logic [WordW-1:0] idReadB;
    logic [WordW-1:0] idImm;
    fwdSelE fwdA;
    fwdSelE fwdB;
    logic stall;
    logic [WordW-1:0] opA;
    logic [WordW-1:0] opBReg;
    logic [WordW-1:0] aluResult;
    logic aluZero;
    logic [WordW-1:0] wbData;
    logic memRegWrite;
    logic wbRegWrite;
    logic branchTaken;
    logic haltNow;

    assign idInstr = ifId.instr;
    assign idValid = ifId.valid;
    // R-type writes rd, the immediate forms write rt
    assign idDest = (opcodeE'(ifId.instr[15:12]) == OpRtype) ? ifId.instr[7:6] : ifId.instr[9:8];
    assign idImm = {{(WordW - 8){ifId.instr[7]}}, ifId.instr[7:0]};

    assign memRegWrite = exMem.valid & exMem.ctrl.regWrite;
    assign wbRegWrite = memWb.valid & memWb.ctrl.regWrite;
    assign wbData = memWb.ctrl.memToReg ? memWb.loadData : memWb.aluResult;
    assign haltNow = memWb.valid & memWb.ctrl.isHalt;

    regFile uRegFile (
        .Clk        (Clk),
        .rst        (rst),
        .readAddrA  (ifId.instr[11:10]),
        .readAddrB  (ifId.instr[9:8]),
        .writeAddr  (memWb.dest),
        .writeData  (wbData),
        .writeEnable(wbRegWrite),
        .readDataA  (idReadA),
        .readDataB  (idReadB)
    );

    hazardUnit uHazard (
        .idRs       (ifId.instr[11:10]),
        .idRt       (ifId.instr[9:8]),
        .exRs       (idEx.rs),
        .exRt       (idEx.rt),
        .idUsesRs   (idCtrl.usesRs),
        .idUsesRt   (idCtrl.usesRt),
        .exUsesRs   (idEx.ctrl.usesRs),
        .exUsesRt   (idEx.ctrl.usesRt),
        .exIsLoad   (idEx.valid & idEx.ctrl.memRead),
        .exDest     (idEx.dest),
        .memDest    (exMem.dest),
        .wbDest     (memWb.dest),
        .memRegWrite(memRegWrite),
        .wbRegWrite (wbRegWrite),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .stall      (stall)
    );

    always_comb begin
        case (fwdA)
            FwdMem: opA = exMem.aluResult;
            FwdWb: opA = wbData;
            default: opA = idEx.readA;
        endcase
        case (fwdB)
            FwdMem: opBReg = exMem.aluResult;
            FwdWb: opBReg = wbData;
            default: opBReg = idEx.readB;
        endcase
    end

    alu uAlu (
        .operandA(opA),
        .operandB(idEx.ctrl.aluSrcImm ? idEx.imm : opBReg),
        .imm     (idEx.imm),
        .aluOp   (idEx.ctrl.aluOp),
        .result  (aluResult),
        .zero    (aluZero)
    );

    assign branchTaken = idEx.valid & idEx.ctrl.isBranch
                       & (idEx.ctrl.branchOnEqual ? aluZero : ~aluZero);

    assign pcPlus1 = pc + WordW'(1);
    always_comb begin
        if (stall) begin
            nextPc = pc;
        end else if (branchTaken) begin
            nextPc = idEx.pcPlus1 + idEx.imm;
        end else if (idCtrl.isJump) begin
            nextPc = {ifId.pcPlus1[WordW-1:12], ifId.instr[11:0]};
        end else begin
            nextPc = pcPlus1;
        end
    end

    assign instAddr = pc;
    assign instRead = ~halted;
    assign dataAddr = exMem.aluResult;
    assign dataRead = exMem.valid & exMem.ctrl.memRead;
    // A store younger than the retiring HLT is dropped
    assign dataWrite = exMem.valid & exMem.ctrl.memWrite & ~haltNow;
    assign dataWriteValue = exMem.storeData;

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= '0;
            ifId <= '0;
            idEx <= '0;
            exMem <= '0;
            memWb <= '0;
            halted <= 1'b0;
        end else if (halted || haltNow) begin
            ifId <= '0;
            idEx <= '0;
            exMem <= '0;
            memWb <= '0;
            halted <= 1'b1;
        end else begin
            pc <= nextPc;
            if (!stall) begin
                if (branchTaken || idCtrl.isJump) begin
                    ifId <= '0;
                end else begin
                    ifId <= '{pcPlus1: pcPlus1, instr: instData, valid: 1'b1};
                end
            end
            if (stall || branchTaken) begin
                idEx <= '0;
            end else begin
                idEx <= '{ctrl: idCtrl, pcPlus1: ifId.pcPlus1, readA: idReadA,
                          readB: idReadB, rs: ifId.instr[11:10], rt: ifId.instr[9:8],
                          dest: idDest, imm: idImm, valid: ifId.valid};
            end
            exMem <= '{ctrl: idEx.ctrl, aluResult: aluResult, storeData: opBReg,
                       dest: idEx.dest, valid: idEx.valid};
            memWb <= '{ctrl: exMem.ctrl, aluResult: exMem.aluResult,
                       loadData: dataReadValue, dest: exMem.dest, valid: exMem.valid};
        end
    end

    // Retire counter and output strobe
    always_ff @(posedge Clk) begin
        if (rst) begin
            numInst <= '0;
            outputValid <= 1'b0;
        end else begin
            outputValid <= memWb.valid & memWb.ctrl.isWwd;
            if (memWb.valid) begin
                numInst <= numInst + WordW'(1);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (memWb.valid && memWb.ctrl.isWwd) begin
            outputPort <= memWb.aluResult;
        end
    end

endmodule

// ==== design/cpuTop.sv ====
`timescale 1ns/1ns

module cpuTop (
    input  logic                     Clk,
    input  logic                     rst,
    output logic [isaPkg::WordW-1:0] instAddr,
    output logic                     instRead,
    input  logic [isaPkg::WordW-1:0] instData,
    output logic [isaPkg::WordW-1:0] dataAddr,
    output logic                     dataRead,
    output logic                     dataWrite,
    output logic [isaPkg::WordW-1:0] dataWriteValue,
    input  logic [isaPkg::WordW-1:0] dataReadValue,
    output logic [isaPkg::WordW-1:0] outputPort,
    output logic                     outputValid,
    output logic [isaPkg::WordW-1:0] numInst,
    output logic                     halted
);
    import isaPkg::*;

    logic [WordW-1:0] idInstr;
    logic idValid;
    ctrlT idCtrl;

    controlUnit uControl (
        .instr(idInstr),
        .valid(idValid),
        .ctrl (idCtrl)
    );

    datapath uDatapath (
        .Clk           (Clk),
        .rst           (rst),
        .idInstr       (idInstr),
        .idValid       (idValid),
        .idCtrl        (idCtrl),
        .instAddr      (instAddr),
        .instRead      (instRead),
        .instData      (instData),
        .dataAddr      (dataAddr),
        .dataRead      (dataRead),
        .dataWrite     (dataWrite),
        .dataWriteValue(dataWriteValue),
        .dataReadValue (dataReadValue),
        .outputPort    (outputPort),
        .outputValid   (outputValid),
        .numInst       (numInst),
        .halted        (halted)
    );

endmodule

// ==== sim/cpu_props.sv ====
`timescale 1ns/1ns

module cpuProps (
    input logic Clk,
    input logic rst,
    input logic dataRead,
    input logic dataWrite,
    input logic instRead,
    input logic outputValid,
    input logic halted
);
    int failCount = 0;

    // Split data bus never reads and writes in one cycle
    noReadWrite: assert property (@(posedge Clk) disable iff (rst) !(dataRead && dataWrite))
    else begin
        $error("dataRead and dataWrite are high in the same cycle");
        failCount++;
    end

    haltStopsFetch: assert property (@(posedge Clk) disable iff (rst) halted |-> !instRead)
    else begin
        $error("instRead is high while the core is halted");
        failCount++;
    end

    // Only reset leaves the halt state
    haltSticky: assert property (@(posedge Clk) disable iff (rst) halted |=> halted)
    else begin
        $error("halted dropped without a reset");
        failCount++;
    end

    resetQuiet: assert property (@(posedge Clk) rst |=> !outputValid)
    else begin
        $error("outputValid is high during reset");
        failCount++;
    end

endmodule

bind datapath cpuProps uProps (
    .Clk        (Clk),
    .rst        (rst),
    .dataRead   (dataRead),
    .dataWrite  (dataWrite),
    .instRead   (instRead),
    .outputValid(outputValid),
    .halted     (halted)
);

// ==== sim/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;
    import isaPkg::*;

    localparam int MemWords = 256;
    localparam int ResetCycles = 4;
    localparam int HoldCycles = 20;
    localparam int MidRunCycles = 20;
    localparam int RefStepLimit = 1000;

    logic Clk;
    logic rst;
    logic [WordW-1:0] instAddr;
    logic instRead;
    logic [WordW-1:0] instData;
    logic [WordW-1:0] dataAddr;
    logic dataRead;
    logic dataWrite;
    logic [WordW-1:0] dataWriteValue;
    logic [WordW-1:0] dataReadValue;
    logic [WordW-1:0] outputPort;
    logic outputValid;
    logic [WordW-1:0] numInst;
    logic halted;

    logic [WordW-1:0] instMem [MemWords];
    logic [WordW-1:0] dataMem [MemWords];
    logic [WordW-1:0] initMem [MemWords];
    logic [WordW-1:0] refMem [MemWords];
    logic [WordW-1:0] expWwd [$];
    int refCount;
    int progLen;
    int wwdIdx = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    initial Clk = 1'b0;
    always #2 Clk = ~Clk;

    cpuTop u_dut (
        .Clk           (Clk),
        .rst           (rst),
        .instAddr      (instAddr),
        .instRead      (instRead),
        .instData      (instData),
        .dataAddr      (dataAddr),
        .dataRead      (dataRead),
        .dataWrite     (dataWrite),
        .dataWriteValue(dataWriteValue),
        .dataReadValue (dataReadValue),
        .outputPort    (outputPort),
        .outputValid   (outputValid),
        .numInst       (numInst),
        .halted        (halted)
    );

    // Both memories answer in the same cycle
    assign instData = instMem[instAddr[7:0]];
    assign dataReadValue = dataRead ? dataMem[dataAddr[7:0]] : '0;

    always @(posedge Clk) begin
        if (dataWrite) begin
            dataMem[dataAddr[7:0]] <= dataWriteValue;
        end
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [WordW-1:0] got,
                                  input logic [WordW-1:0] exp);
        failRun($sformatf("Fail %s: got 0x%04h, expected 0x%04h", name, got, exp));
    endtask

    task automatic emitR(input funcE fn, input int rs, input int rt, input int rd);
        instMem[progLen] = {OpRtype, 2'(rs), 2'(rt), 2'(rd), fn};
        progLen++;
    endtask

    task automatic emitI(input opcodeE op, input int rs, input int rt, input int imm);
        instMem[progLen] = {op, 2'(rs), 2'(rt), 8'(imm)};
        progLen++;
    endtask

    task automatic emitJmp(input int target);
        instMem[progLen] = {OpJmp, 12'(target)};
        progLen++;
    endtask

    task automatic loadProgram();
        progLen = 0;
        // Dependent ALU chain with operands from memory, write-back and the register file
        emitI(OpLhi, 0, 1, 8'h12);
        emitI(OpAdi, 1, 1, 8'h34);
        emitI(OpAdi, 1, 2, 5);
        emitR(FnAdd, 1, 2, 3);
        emitR(FnWwd, 3, 0, 0);
        emitR(FnSub, 3, 1, 0);
        emitR(FnWwd, 0, 0, 0);
        emitR(FnAnd, 0, 3, 2);
        emitR(FnOrr, 2, 0, 1);
        emitR(FnWwd, 1, 0, 0);
        emitR(FnWwd, 2, 0, 0);
        // Load-use pairs and a store then load of the same word
        emitI(OpLhi, 0, 0, 0);
        emitI(OpAdi, 0, 0, 8'h10);
        emitI(OpLwd, 0, 1, 3);
        emitR(FnAdd, 1, 1, 2);
        emitR(FnWwd, 2, 0, 0);
        emitI(OpSwd, 0, 2, 5);
        emitI(OpLwd, 0, 3, 5);
        emitR(FnWwd, 3, 0, 0);
        emitI(OpLwd, 0, 1, 7);
        emitI(OpSwd, 0, 1, 8);
        emitI(OpLwd, 0, 2, 8);
        emitI(OpAdi, 2, 2, 1);
        emitR(FnWwd, 2, 0, 0);
        // Branches, a counted loop and a jump that skip words 26, 27, 38, 39 and 41
        emitI(OpAdi, 0, 3, 0);
        emitI(OpBeq, 3, 0, 2);
        emitR(FnWwd, 1, 0, 0);
        emitR(FnWwd, 2, 0, 0);
        emitI(OpBne, 3, 0, 1);
        emitR(FnWwd, 3, 0, 0);
        emitI(OpBeq, 1, 2, 1);
        emitI(OpLhi, 0, 1, 0);
        emitI(OpAdi, 1, 1, 3);
        emitI(OpLhi, 0, 2, 0);
        emitR(FnWwd, 1, 0, 0);
        emitI(OpAdi, 1, 1, -1);
        emitI(OpBne, 1, 2, -3);
        emitJmp(40);
        emitR(FnWwd, 0, 0, 0);
        emitR(FnWwd, 3, 0, 0);
        emitI(OpBeq, 1, 2, 1);
        emitR(FnWwd, 0, 0, 0);
        emitR(FnWwd, 2, 0, 0);
        emitR(FnHlt, 0, 0, 0);
        // A store and a WWD behind HLT that must never take effect
        emitI(OpSwd, 0, 3, 0);
        emitR(FnWwd, 3, 0, 0);
    endtask

    function automatic logic [WordW-1:0] signExt8(input logic [7:0] v);
        return {{(WordW - 8){v[7]}}, v};
    endfunction

    // Executes one instruction at a time from instMem starting at address 0
    function automatic void runReference();
        logic [WordW-1:0] regs [NumRegs];
        logic [WordW-1:0] pc;
        logic [WordW-1:0] ir;
        logic [WordW-1:0] a;
        logic [WordW-1:0] b;
        logic [WordW-1:0] imm;
        logic [WordW-1:0] addr;
        logic [1:0] rt;
        logic [1:0] rd;
        bit running;
        regs = '{default: '0};
        pc = '0;
        refCount = 0;
        expWwd.delete();
        for (int i = 0; i < MemWords; i++) begin
            refMem[i] = initMem[i];
        end
        running = 1'b1;
        while (running && refCount < RefStepLimit) begin
            ir = instMem[pc[7:0]];
            a = regs[ir[11:10]];
            b = regs[ir[9:8]];
            rt = ir[9:8];
            rd = ir[7:6];
            imm = signExt8(ir[7:0]);
            addr = a + imm;
            refCount++;
            pc = pc + 16'd1;
            case (ir[15:12])
                OpRtype: begin
                    case (ir[5:0])
                        FnAdd: regs[rd] = a + b;
                        FnSub: regs[rd] = a - b;
                        FnAnd: regs[rd] = a & b;
                        FnOrr: regs[rd] = a | b;
                        FnWwd: expWwd.push_back(a);
                        FnHlt: running = 1'b0;
                        default: ;
                    endcase
                end
                OpAdi: regs[rt] = a + imm;
                OpLhi: regs[rt] = {ir[7:0], 8'h00};
                OpLwd: regs[rt] = refMem[addr[7:0]];
                OpSwd: refMem[addr[7:0]] = b;
                // pc already points past the branch
                OpBne: pc = (a != b) ? pc + imm : pc;
                OpBeq: pc = (a == b) ? pc + imm : pc;
                OpJmp: pc = {pc[15:12], ir[11:0]};
                default: ;
            endcase
        end
    endfunction

    task automatic restoreData();
        for (int i = 0; i < MemWords; i++) begin
            dataMem[i] = initMem[i];
        end
    endtask

    task automatic checkResetState();
        assert (halted == 1'b0) else reportMismatch("halted", halted, 0);
        assert (numInst == '0) else reportMismatch("numInst", numInst, 0);
        assert (instAddr == '0) else reportMismatch("instAddr", instAddr, 0);
        assert (instRead == 1'b1) else reportMismatch("instRead", instRead, 1);
        assert (dataRead == 1'b0) else reportMismatch("dataRead", dataRead, 0);
        assert (dataWrite == 1'b0) else reportMismatch("dataWrite", dataWrite, 0);
        assert (outputValid == 1'b0) else reportMismatch("outputValid", outputValid, 0);
    endtask

    // Called at a rising edge or at time zero
    task automatic applyReset();
        rst <= 1'b1;
        repeat (ResetCycles - 1) @(posedge Clk);
        @(negedge Clk);
        checkResetState();
        restoreData();
        wwdIdx = 0;
        @(posedge Clk);
        rst <= 1'b0;
    endtask

    task automatic waitForHalt();
        while (halted !== 1'b1) begin
            @(negedge Clk);
        end
    endtask

    task automatic checkFinalState();
        assert (numInst == WordW'(refCount))
        else reportMismatch("numInst", numInst, WordW'(refCount));
        assert (wwdIdx == expWwd.size())
        else failRun($sformatf("Only %0d of %0d WWD values appeared before halt",
                               wwdIdx, expWwd.size()));
        for (int i = 0; i < MemWords; i++) begin
            assert (dataMem[i] == refMem[i])
            else reportMismatch($sformatf("dataMem[%0d]", i), dataMem[i], refMem[i]);
        end
        repeat (HoldCycles) begin
            @(negedge Clk);
            assert (halted == 1'b1) else failRun("halted dropped while the core should stay halted");
            assert (instRead == 1'b0) else failRun("instruction fetch resumed after HLT");
            assert (outputValid == 1'b0) else failRun("outputValid pulsed after HLT");
            assert (numInst == WordW'(refCount))
            else reportMismatch("numInst", numInst, WordW'(refCount));
        end
    endtask

    // Compares every output strobe with the next reference WWD value
    always @(negedge Clk) begin
        assert (u_dut.uDatapath.uProps.failCount == 0)
        else failRun("A bound pipeline property failed");
        if (!rst && outputValid) begin
            assert (wwdIdx < expWwd.size())
            else failRun("outputValid pulsed more often than the program writes WWD values");
            assert (outputPort == expWwd[wwdIdx])
            else reportMismatch("outputPort", outputPort, expWwd[wwdIdx]);
            wwdIdx++;
        end
    end

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            failRun($sformatf("Timeout after %0d cycles, the core never finished", cycleCount));
        end
    end

    initial begin
        rst = 1'b1;
        void'($urandom(28));
        for (int i = 0; i < MemWords; i++) begin
            initMem[i] = 16'($urandom());
            dataMem[i] = initMem[i];
            // Unused words jump to themselves so a runaway fetch ends in the timeout
            instMem[i] = {OpJmp, 12'(i)};
        end
        loadProgram();
        runReference();
        assert (refCount < RefStepLimit) else failRun("Reference interpreter never reached HLT");
        // Two full runs plus hold, mid-run stretch and three resets
        cycleLimit = 2 * (8 * refCount + 50) + HoldCycles + MidRunCycles + 3 * ResetCycles;

        applyReset();
        waitForHalt();
        checkFinalState();

        // Second run is cut short by a reset
        @(posedge Clk);
        applyReset();
        repeat (MidRunCycles) @(negedge Clk);
        assert (halted == 1'b0) else failRun("Core halted before the mid-run reset");
        assert (numInst != '0) else failRun("No instruction retired before the mid-run reset");
        assert (wwdIdx > 0) else failRun("No WWD value appeared before the mid-run reset");
        @(posedge Clk);
        applyReset();
        waitForHalt();
        checkFinalState();

        if (u_dut.uDatapath.uProps.failCount == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            failRun("A bound pipeline property failed");
        end
    end

endmodule

// ==== verilog.f ====
design/isaPkg.sv
design/pipePkg.sv
design/controlUnit.sv
design/regFile.sv
design/alu.sv
design/hazardUnit.sv
design/datapath.sv
design/cpuTop.sv
sim/cpu_props.sv
sim/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu_pipeline

sources:
  - design/isaPkg.sv
  - design/pipePkg.sv
  - design/controlUnit.sv
  - design/regFile.sv
  - design/alu.sv
  - design/hazardUnit.sv
  - design/datapath.sv
  - design/cpuTop.sv
  - target: simulation
    files:
      - sim/cpu_props.sv
      - sim/tb_cpu.sv
